/* tb.f */
design/cpuPkg.sv
design/instrClassifier.sv
design/aluControl.sv
design/aluCore.sv
design/exInputLatch.sv
design/exOutputLatch.sv
design/executeUnit.sv
+incdir+dv
dv/tbExecuteUnit.sv

/* dv/exRefModel.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1.
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

function automatic instrClassT classOf(input instrT instr);
    case (instr)
        ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI: return classCalcI;
        LW:  return classMemRead;
        SW:  return classMemWrite;
        NOP: return classNone;
        default: return classCalcR;
    endcase
endfunction

// logical immediates are zero extended.
function automatic logic [31:0] extendImm(input instrT instr, input logic [15:0] imm);
    if (instr == ANDI || instr == ORI || instr == XORI || instr == LUI)
    begin
        return {16'h0000, imm};
    end
    return {{16{imm[15]}}, imm};
endfunction

function automatic logic [31:0] leadingCount(input logic [31:0] value, input logic bitVal);
    int n;
    n = 0;
    while (n < 32 && value[31 - n] == bitVal)
    begin
        n++;
    end
    return n;
endfunction

function automatic exResultT expectResult(input issueT it);
    exResultT exp;
    logic [31:0] imm;
    logic [31:0] rs;
    logic [31:0] rt;
    instrClassT cls;
    cls = classOf(it.instr);
    imm = extendImm(it.instr, it.imm16);
    rs  = it.dataRs;
    rt  = it.dataRt;
    exp = '0;
    exp.valid = 1'b1;
    exp.dest  = it.dest;
    case (it.instr)
        ADD, ADDU:   exp.result = rs + rt;
        SUB, SUBU:   exp.result = rs - rt;
        AND:         exp.result = rs & rt;
        OR:          exp.result = rs | rt;
        XOR:         exp.result = rs ^ rt;
        NOR:         exp.result = ~(rs | rt);
        SLT:         exp.result = ($signed(rs) < $signed(rt)) ? 1 : 0;
        SLTU:        exp.result = (rs < rt) ? 1 : 0;
        SLL:         exp.result = rt << it.shamt;
        SRL:         exp.result = rt >> it.shamt;
        SRA:         exp.result = $signed(rt) >>> it.shamt;
        SLLV:        exp.result = rt << rs[4:0];
        SRLV:        exp.result = rt >> rs[4:0];
        SRAV:        exp.result = $signed(rt) >>> rs[4:0];
        ADDI, ADDIU: exp.result = rs + imm;
        ANDI:        exp.result = rs & imm;
        ORI:         exp.result = rs | imm;
        XORI:        exp.result = rs ^ imm;
        SLTI:        exp.result = ($signed(rs) < $signed(imm)) ? 1 : 0;
        SLTIU:       exp.result = (rs < imm) ? 1 : 0;
        LUI:         exp.result = {it.imm16, 16'h0000};
        CLO:         exp.result = leadingCount(rs, 1'b1);
        CLZ:         exp.result = leadingCount(rs, 1'b0);
        LW, SW:      exp.result = rs + imm; // address.
        default:     exp.result = '0;
    endcase
    exp.regWrite = (cls == classCalcR || cls == classCalcI || cls == classMemRead);
    exp.memRead  = (cls == classMemRead);
    exp.memWrite = (cls == classMemWrite);
    return exp;
endfunction

`endif

/* dv/tbExecuteUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module tbExecuteUnit;
    import cpuPkg::*;

    `include "exRefModel.svh"

    logic     clk;
    logic     rstN;
    issueT    issue;
    exResultT exOut;

    logic [31:0] lfsrState;
    exResultT    expQueue[$];
    int          dueQueue[$];
    int          cycle;
    int          errors;
    int          checks;
    int          waitCount;
    issueT       item;
    logic [31:0] boundary[5];

    executeUnit u_executeUnit (
        .clk   (clk),
        .rstN  (rstN),
        .issue (issue),
        .exOut (exOut)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // one lfsr step per bit taken.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] pickOperand();
        logic [31:0] sel;
        sel = randBits(3);
        if (sel < 5)
        begin
            return boundary[sel];
        end
        return randBits(32);
    endfunction

    task automatic sendItem(input issueT it);
        @(negedge clk);
        issue = it;
        if (it.valid)
        begin
            expQueue.push_back(expectResult(it));
            dueQueue.push_back(cycle + 2); // two edges of latency.
        end
    endtask

    // outputs are stable at the falling edge.
    always @(negedge clk)
    begin
        exResultT exp;
        int due;
        if (rstN === 1'b1 && exOut.valid !== 1'b0)
        begin
            checks++;
            if (exOut.valid !== 1'b1)
            begin
                $display("error at %0t: exOut.valid is unknown", $time);
                errors++;
            end
            else if (expQueue.size() == 0)
            begin
                $display("error at %0t: output with no item in flight", $time);
                errors++;
            end
            else
            begin
                exp = expQueue.pop_front();
                due = dueQueue.pop_front();
                if (cycle != due)
                begin
                    $display("error at %0t: output at cycle %0d, expected %0d", $time, cycle, due);
                    errors++;
                end
                if (exOut.result !== exp.result)
                begin
                    $display("error at %0t: result %h, expected %h", $time, exOut.result,
                             exp.result);
                    errors++;
                end
                if (exOut.dest !== exp.dest)
                begin
                    $display("error at %0t: dest %0d, expected %0d", $time, exOut.dest, exp.dest);
                    errors++;
                end
                if (exOut.regWrite !== exp.regWrite || exOut.memRead !== exp.memRead
                    || exOut.memWrite !== exp.memWrite)
                begin
                    $display("error at %0t: flags %b%b%b, expected %b%b%b", $time,
                             exOut.regWrite, exOut.memRead, exOut.memWrite,
                             exp.regWrite, exp.memRead, exp.memWrite);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        clk       = 1'b0;
        rstN      = 1'b0;
        issue     = '0;
        cycle     = 0;
        errors    = 0;
        checks    = 0;
        lfsrState = 32'd28;
        boundary  = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                      32'h8000_0000, 32'hffff_ffff};
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        repeat (3) @(negedge clk); // valid must stay low here.

        // directed boundary pairs for every instruction, back to back.
        for (int op = 0; op < 29; op++)
        begin
            for (int a = 0; a < 5; a++)
            begin
                for (int b = 0; b < 5; b++)
                begin
                    item        = '0;
                    item.valid  = 1'b1;
                    item.instr  = instrT'(op);
                    item.dataRs = boundary[a];
                    item.dataRt = boundary[b];
                    item.imm16  = boundary[b][15:0] ^ {a[0], 15'h0};
                    item.shamt  = boundary[(a + b) % 5][4:0];
                    item.dest   = op[4:0] ^ a[4:0];
                    sendItem(item);
                end
            end
        end

        // random items with idle gaps.
        for (int n = 0; n < 2000; n++)
        begin
            item        = '0;
            item.valid  = (randBits(2) != 0);
            item.instr  = instrT'(randBits(6) % 29);
            item.dataRs = pickOperand();
            item.dataRt = pickOperand();
            item.imm16  = randBits(16);
            item.shamt  = randBits(5);
            item.dest   = randBits(5);
            sendItem(item);
        end

        @(negedge clk);
        issue = '0;
        waitCount = 0;
        while (expQueue.size() != 0 && waitCount < 100)
        begin
            @(negedge clk);
            waitCount++;
        end
        if (expQueue.size() != 0)
        begin
            $display("timed out waiting for %0d outstanding results", expQueue.size());
            errors++;
        end
        repeat (4) @(negedge clk); // idle cycles, no stray output.

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::issueT    issue,
    output cpuPkg::exResultT exOut
);
    import cpuPkg::*;

    issueT      stageIn;
    instrClassT instrClass;
    aluOpT      aluOp;
    extModeT    extMode;
    logic       shiftByShamt;
    wordT       aluResult;

    exInputLatch u_exInputLatch (
        .clk     (clk),
        .rstN    (rstN),
        .issue   (issue),
        .stageIn (stageIn)
    );

    instrClassifier u_instrClassifier (
        .instr      (stageIn.instr),
        .instrClass (instrClass)
    );

    aluControl u_aluControl (
        .instr        (stageIn.instr),
        .instrClass   (instrClass),
        .aluOp        (aluOp),
        .extMode      (extMode),
        .shiftByShamt (shiftByShamt)
    );

    aluCore u_aluCore (
        .aluOp        (aluOp),
        .extMode      (extMode),
        .shiftByShamt (shiftByShamt),
        .instrClass   (instrClass),
        .dataRs       (stageIn.dataRs),
        .dataRt       (stageIn.dataRt),
        .imm16        (stageIn.imm16),
        .shamt        (stageIn.shamt),
        .result       (aluResult)
    );

    exOutputLatch u_exOutputLatch (
        .clk        (clk),
        .rstN       (rstN),
        .valid      (stageIn.valid),
        .result     (aluResult),
        .dest       (stageIn.dest),
        .instrClass (instrClass),
        .exOut      (exOut)
    );

endmodule

`default_nettype wire

/* design/exOutputLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module exOutputLatch (
    input  logic               clk,
    input  logic               rstN,
    input  logic               valid,
    input  cpuPkg::wordT       result,
    input  cpuPkg::regIdxT     dest,
    input  cpuPkg::instrClassT instrClass,
    output cpuPkg::exResultT   exOut
);
    import cpuPkg::*;

    logic regWrite;
    logic memRead;
    logic memWrite;

    // flags only go out with a live item.
    assign regWrite = valid && (instrClass == classCalcR
                             || instrClass == classCalcI
                             || instrClass == classMemRead);
    assign memRead  = valid && (instrClass == classMemRead);
    assign memWrite = valid && (instrClass == classMemWrite);

    always_ff @(posedge clk)
    begin
        exOut.result <= result;
        exOut.dest   <= dest;
        if (!rstN)
        begin
            exOut.valid    <= 1'b0;
            exOut.regWrite <= 1'b0;
            exOut.memRead  <= 1'b0;
            exOut.memWrite <= 1'b0;
        end
        else
        begin
            exOut.valid    <= valid;
            exOut.regWrite <= regWrite;
            exOut.memRead  <= memRead;
            exOut.memWrite <= memWrite;
        end
    end

    // memory stage can do one access per item.
    memFlagsExclusive: assert property (
        @(posedge clk) disable iff (rstN !== 1'b1)
        !(exOut.memRead && exOut.memWrite)
    ) else $error("exOutputLatch: memRead and memWrite both set");

endmodule

`default_nettype wire

/* design/exInputLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module exInputLatch (
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::issueT issue,
    output cpuPkg::issueT stageIn
);
    import cpuPkg::*;

    // no stall, so a new bundle is taken every cycle.
    always_ff @(posedge clk)
    begin
        stageIn <= issue;
        if (!rstN)
        begin
            stageIn.valid <= 1'b0; // payload left as is.
        end
    end

    validKnown: assert property (
        @(posedge clk) disable iff (rstN !== 1'b1)
        !$isunknown(stageIn.valid)
    ) else $error("exInputLatch: stage valid unknown out of reset");

endmodule

`default_nettype wire

/* design/aluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  cpuPkg::aluOpT      aluOp,
    input  cpuPkg::extModeT    extMode,
    input  logic               shiftByShamt,
    input  cpuPkg::instrClassT instrClass,
    input  cpuPkg::wordT       dataRs,
    input  cpuPkg::wordT       dataRt,
    input  cpuPkg::imm16T      imm16,
    input  cpuPkg::shamtT      shamt,
    output cpuPkg::wordT       result
);
    import cpuPkg::*;

    wordT extImm;
    wordT srcA;
    wordT srcB;
    wordT onesCount;
    wordT zerosCount;

    // leading run of bitVal from the msb, 0 to 32.
    function automatic wordT countLeading(input wordT value, input logic bitVal);
        wordT count;
        logic done;
        count = '0;
        done  = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (!done && value[i] == bitVal)
            begin
                count = count + 1;
            end
            else
            begin
                done = 1'b1;
            end
        end
        return count;
    endfunction

    assign extImm = (extMode == extSign) ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

    assign srcA = shiftByShamt ? {27'b0, shamt} : dataRs;

    always_comb
    begin
        case (instrClass)
            classCalcI,
            classMemRead,
            classMemWrite:
            begin
                srcB = extImm;
            end
            classCalcR:
            begin
                srcB = dataRt;
            end
            default:
            begin
                srcB = '0;
            end
        endcase
    end

    assign onesCount  = countLeading(srcA, 1'b1);
    assign zerosCount = countLeading(srcA, 1'b0);

    always_comb
    begin
        case (aluOp)
            aluZero: result = '0;
            aluA:    result = srcA;
            aluB:    result = srcB;
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluNor:  result = ~(srcA | srcB);
            aluSlt:  result = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            aluSltu: result = (srcA < srcB) ? 32'd1 : 32'd0;
            aluSll:  result = srcB << srcA[4:0];
            aluSrl:  result = srcB >> srcA[4:0];
            aluSra:  result = $signed(srcB) >>> srcA[4:0]; // keeps the sign.
            aluLui:  result = {srcB[15:0], 16'b0};
            aluClo:  result = onesCount;
            aluClz:  result = zerosCount;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/aluControl.sv */
`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input  cpuPkg::instrT      instr,
    input  cpuPkg::instrClassT instrClass,
    output cpuPkg::aluOpT      aluOp,
    output cpuPkg::extModeT    extMode,
    output logic               shiftByShamt
);
    import cpuPkg::*;

    logic isMem;

    assign isMem = (instrClass == classMemRead) || (instrClass == classMemWrite);

    always_comb
    begin
        if (isMem)
        begin
            extMode = extSign; // address offset is signed.
        end
        else if (instr == ANDI || instr == ORI || instr == XORI || instr == LUI)
        begin
            extMode = extZero;
        end
        else
        begin
            extMode = extSign;
        end
    end

    always_comb
    begin
        if (isMem)
        begin
            aluOp = aluAdd; // address generation.
        end
        else
        begin
            case (instr)
                ADD, ADDU, ADDI, ADDIU: aluOp = aluAdd;
                SUB, SUBU:              aluOp = aluSub;
                AND, ANDI:              aluOp = aluAnd;
                OR, ORI:                aluOp = aluOr;
                XOR, XORI:              aluOp = aluXor;
                NOR:                    aluOp = aluNor;
                SLT, SLTI:              aluOp = aluSlt;
                SLTU, SLTIU:            aluOp = aluSltu;
                SLL, SLLV:              aluOp = aluSll;
                SRL, SRLV:              aluOp = aluSrl;
                SRA, SRAV:              aluOp = aluSra;
                LUI:                    aluOp = aluLui;
                CLO:                    aluOp = aluClo;
                CLZ:                    aluOp = aluClz;
                default:                aluOp = aluZero;
            endcase
        end
    end

    // fixed shifts take the amount from the shamt field.
    assign shiftByShamt = (instr == SLL) || (instr == SRL) || (instr == SRA);

    // classifier and control tables must agree.
    opMatchesClass: assert final (instrClass == classNone || aluOp != aluZero)
        else $error("aluControl: class %s gave aluZero for %s", instrClass.name(), instr.name());

endmodule

`default_nettype wire

/* design/instrClassifier.sv */
`timescale 1ns/1ps
`default_nettype none

module instrClassifier (
    input  cpuPkg::instrT      instr,
    output cpuPkg::instrClassT instrClass
);
    import cpuPkg::*;

    always_comb
    begin
        case (instr)
            ADD,
            ADDU,
            SUB,
            SUBU,
            AND,
            OR,
            XOR,
            NOR,
            SLT,
            SLTU,
            SLL,
            SRL,
            SRA,
            SLLV,
            SRLV,
            SRAV,
            CLO,
            CLZ:
            begin
                instrClass = classCalcR;
            end
            ADDI,
            ADDIU,
            ANDI,
            ORI,
            XORI,
            SLTI,
            SLTIU,
            LUI:
            begin
                instrClass = classCalcI;
            end
            LW:
            begin
                instrClass = classMemRead;
            end
            SW:
            begin
                instrClass = classMemWrite;
            end
            default:
            begin
                instrClass = classNone; // nop and unknown ids.
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [15:0] imm16T;
    typedef logic [4:0]  shamtT;
    typedef logic [4:0]  regIdxT;

    // decoded instruction id, produced by the decode stage.
    typedef enum logic [5:0] {
        NOP,
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        SLLV,
        SRLV,
        SRAV,
        ADDI,
        ADDIU,
        ANDI,
        ORI,
        XORI,
        SLTI,
        SLTIU,
        LUI,
        CLO,
        CLZ,
        LW,
        SW
    } instrT;

    typedef enum logic [2:0] {
        classNone,
        classCalcR,
        classCalcI,
        classMemRead,
        classMemWrite
    } instrClassT;

    typedef enum logic [4:0] {
        aluZero,
        aluA,
        aluB,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui,
        aluClo,
        aluClz
    } aluOpT;

    typedef enum logic {
        extZero = 1'b0,
        extSign = 1'b1
    } extModeT;

    typedef struct packed {
        logic   valid;
        instrT  instr;
        wordT   dataRs;
        wordT   dataRt;
        imm16T  imm16;
        shamtT  shamt;
        regIdxT dest;
    } issueT;

    typedef struct packed {
        logic   valid;
        wordT   result;
        regIdxT dest;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
    } exResultT;

endpackage

`default_nettype wire
